// ==== include/zynq_glue_config.svh ====
`ifndef ZYNQ_GLUE_CONFIG_SVH
`define ZYNQ_GLUE_CONFIG_SVH

// bus widths seen by the host and by the core
`define ZG_ADDR_W        32
`define ZG_DATA_W        32

// register map: index width and the number of host-writable registers
`define ZG_CSR_IDX_W     3
`define ZG_CSR_NUM       3

// host bit 29 picks core DRAM or core local space, the low 28 bits pass through
`define ZG_HOST_IDX_BIT  29
`define ZG_HOST_OFS_W    28

// core DRAM starts here, the xor strips it before the PS base is added
`define ZG_DRAM_XOR      32'h8000_0000

// profiler bitmap, one bit per 8 MB region taken from address bits 29..23
`define ZG_PROF_W        128
`define ZG_PROF_HI       29
`define ZG_PROF_IDX_W    7

`endif

// ==== src/zynq_glue_pkg.sv ====
`default_nettype none

`include "zynq_glue_config.svh"

package zynq_glue_pkg;

   // host register map, index 7 is left unmapped and reads as zero
   typedef enum logic [`ZG_CSR_IDX_W-1:0] {
      CSR_CTRL       = 0,
      CSR_DRAM_VALID = 1,
      CSR_DRAM_BASE  = 2,
      CSR_PROF0      = 3,
      CSR_PROF1      = 4,
      CSR_PROF2      = 5,
      CSR_PROF3      = 6
   } csr_addr_e;

   // one address request, valid is a level with no handshake
   typedef struct packed {
      logic                  valid;
      logic [`ZG_ADDR_W-1:0] addr;
   } addr_req_t;

   // host register write, takes effect at the edge where we is high
   typedef struct packed {
      logic                  we;
      csr_addr_e             idx;
      logic [`ZG_DATA_W-1:0] data;
   } csr_wr_t;

endpackage

`default_nettype wire

// ==== src/zynq_csr_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "zynq_glue_config.svh"

module zynq_csr_bank (
   input  logic                     aclk_i,
   input  logic                     arst_n_i,
   input  zynq_glue_pkg::csr_wr_t   csr_wr_i,
   input  logic                     csr_re_i,
   input  zynq_glue_pkg::csr_addr_e csr_raddr_i,
   input  logic [`ZG_PROF_W-1:0]    prof_bits_i,
   output logic [`ZG_DATA_W-1:0]    csr_rdata_o,
   output logic                     csr_rvalid_o,
   output logic [`ZG_ADDR_W-1:0]    dram_base_o,
   output logic                     core_reset_o
);
   import zynq_glue_pkg::*;

   localparam int prof_words_lp = `ZG_PROF_W / `ZG_DATA_W;

   logic [`ZG_CSR_NUM-1:0][`ZG_DATA_W-1:0]  csr_q;
   logic [prof_words_lp-1:0][`ZG_DATA_W-1:0] prof_word;
   logic [`ZG_DATA_W-1:0]                    rd_mux;
   logic [`ZG_DATA_W-1:0]                    rdata_q;
   logic                                     rvalid_q;

   // word k of the bitmap is bits 32k+31 down to 32k
   assign prof_word = prof_bits_i;

   // only control, dram valid and dram base are writable
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         csr_q <= '0;
      end else if (csr_wr_i.we) begin
         case (csr_wr_i.idx)
            CSR_CTRL, CSR_DRAM_VALID, CSR_DRAM_BASE: csr_q[csr_wr_i.idx] <= csr_wr_i.data;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (csr_raddr_i)
         CSR_CTRL:       rd_mux = csr_q[CSR_CTRL];
         CSR_DRAM_VALID: rd_mux = csr_q[CSR_DRAM_VALID];
         CSR_DRAM_BASE:  rd_mux = csr_q[CSR_DRAM_BASE];
         CSR_PROF0:      rd_mux = prof_word[0];
         CSR_PROF1:      rd_mux = prof_word[1];
         CSR_PROF2:      rd_mux = prof_word[2];
         CSR_PROF3:      rd_mux = prof_word[3];
         default:        rd_mux = '0;
      endcase
   end

   // read data is sampled at the strobe edge and valid for one cycle after it
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= csr_re_i;
      end
   end

   always_ff @(posedge aclk_i) begin
      if (csr_re_i) begin
         rdata_q <= rd_mux;
      end
   end

   assign csr_rdata_o  = rdata_q;
   assign csr_rvalid_o = rvalid_q;
   assign dram_base_o  = csr_q[CSR_DRAM_BASE];

   // the core runs only once the host sets control bit 0, so a regression
   // can be restarted without reloading the bitstream
   assign core_reset_o = ~csr_q[CSR_CTRL][0] | ~arst_n_i;

endmodule

`default_nettype wire

// ==== src/zynq_addr_map.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "zynq_glue_config.svh"

module zynq_addr_map (
   input  logic                     aclk_i,
   input  logic                     arst_n_i,
   input  zynq_glue_pkg::addr_req_t host_wr_i,
   input  zynq_glue_pkg::addr_req_t host_rd_i,
   input  zynq_glue_pkg::addr_req_t dram_wr_i,
   input  zynq_glue_pkg::addr_req_t dram_rd_i,
   input  logic [`ZG_ADDR_W-1:0]    dram_base_i,
   output zynq_glue_pkg::addr_req_t core_wr_o,
   output zynq_glue_pkg::addr_req_t core_rd_o,
   output zynq_glue_pkg::addr_req_t ps_wr_o,
   output zynq_glue_pkg::addr_req_t ps_rd_o
);

   logic                  core_wr_v_q, core_rd_v_q, ps_wr_v_q, ps_rd_v_q;
   logic [`ZG_ADDR_W-1:0] core_wr_a_q, core_rd_a_q, ps_wr_a_q, ps_rd_a_q;

   // host 0x0xxx_xxxx lands in core DRAM at 0x8xxx_xxxx,
   // host 0x2xxx_xxxx lands in core local space at 0x0xxx_xxxx
   function automatic logic [`ZG_ADDR_W-1:0] host_xlate(input logic [`ZG_ADDR_W-1:0] a);
      return {~a[`ZG_HOST_IDX_BIT],
              {(`ZG_ADDR_W - 1 - `ZG_HOST_OFS_W){1'b0}},
              a[`ZG_HOST_OFS_W-1:0]};
   endfunction

   // strip the core DRAM base and move into the buffer the PS allocated
   function automatic logic [`ZG_ADDR_W-1:0] dram_xlate(input logic [`ZG_ADDR_W-1:0] a,
                                                        input logic [`ZG_ADDR_W-1:0] base);
      return (a ^ `ZG_DRAM_XOR) + base;
   endfunction

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         core_wr_v_q <= 1'b0;
         core_rd_v_q <= 1'b0;
         ps_wr_v_q   <= 1'b0;
         ps_rd_v_q   <= 1'b0;
      end else begin
         core_wr_v_q <= host_wr_i.valid;
         core_rd_v_q <= host_rd_i.valid;
         ps_wr_v_q   <= dram_wr_i.valid;
         ps_rd_v_q   <= dram_rd_i.valid;
      end
   end

   // addresses only load with a request, they are don't-care otherwise
   always_ff @(posedge aclk_i) begin
      if (host_wr_i.valid) begin
         core_wr_a_q <= host_xlate(host_wr_i.addr);
      end
      if (host_rd_i.valid) begin
         core_rd_a_q <= host_xlate(host_rd_i.addr);
      end
      if (dram_wr_i.valid) begin
         ps_wr_a_q <= dram_xlate(dram_wr_i.addr, dram_base_i);
      end
      if (dram_rd_i.valid) begin
         ps_rd_a_q <= dram_xlate(dram_rd_i.addr, dram_base_i);
      end
   end

   assign core_wr_o = '{valid: core_wr_v_q, addr: core_wr_a_q};
   assign core_rd_o = '{valid: core_rd_v_q, addr: core_rd_a_q};
   assign ps_wr_o   = '{valid: ps_wr_v_q, addr: ps_wr_a_q};
   assign ps_rd_o   = '{valid: ps_rd_v_q, addr: ps_rd_a_q};

endmodule

`default_nettype wire

// ==== src/dram_profiler.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "zynq_glue_config.svh"

module dram_profiler (
   input  logic                     aclk_i,
   input  logic                     core_reset_i,
   input  zynq_glue_pkg::addr_req_t dram_wr_i,
   input  zynq_glue_pkg::addr_req_t dram_rd_i,
   output logic [`ZG_PROF_W-1:0]    prof_bits_o
);

   logic [`ZG_PROF_W-1:0]     prof_q;
   logic [`ZG_PROF_W-1:0]     wr_hit;
   logic [`ZG_PROF_W-1:0]     rd_hit;
   logic [`ZG_PROF_IDX_W-1:0] wr_idx;
   logic [`ZG_PROF_IDX_W-1:0] rd_idx;

   // each bit stands for one 8 MB region of core DRAM
   assign wr_idx = dram_wr_i.addr[`ZG_PROF_HI -: `ZG_PROF_IDX_W];
   assign rd_idx = dram_rd_i.addr[`ZG_PROF_HI -: `ZG_PROF_IDX_W];

   always_comb begin
      wr_hit         = '0;
      rd_hit         = '0;
      wr_hit[wr_idx] = dram_wr_i.valid;
      rd_hit[rd_idx] = dram_rd_i.valid;
   end

   // bits are sticky until the core is put back into reset
   always_ff @(posedge aclk_i) begin
      if (core_reset_i) begin
         prof_q <= '0;
      end else begin
         prof_q <= prof_q | wr_hit | rd_hit;
      end
   end

   assign prof_bits_o = prof_q;

endmodule

`default_nettype wire

// ==== src/zynq_glue_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "zynq_glue_config.svh"

module zynq_glue_top (
   input  logic                     aclk_i,
   input  logic                     arst_n_i,

   // host register access
   input  zynq_glue_pkg::csr_wr_t   csr_wr_i,
   input  logic                     csr_re_i,
   input  zynq_glue_pkg::csr_addr_e csr_raddr_i,
   output logic [`ZG_DATA_W-1:0]    csr_rdata_o,
   output logic                     csr_rvalid_o,

   // host requests into the core
   input  zynq_glue_pkg::addr_req_t host_wr_i,
   input  zynq_glue_pkg::addr_req_t host_rd_i,
   output zynq_glue_pkg::addr_req_t core_wr_o,
   output zynq_glue_pkg::addr_req_t core_rd_o,

   // core DRAM requests out to the PS
   input  zynq_glue_pkg::addr_req_t dram_wr_i,
   input  zynq_glue_pkg::addr_req_t dram_rd_i,
   output zynq_glue_pkg::addr_req_t ps_wr_o,
   output zynq_glue_pkg::addr_req_t ps_rd_o,

   output logic                     core_reset_o
);

   logic [`ZG_ADDR_W-1:0] dram_base;
   logic [`ZG_PROF_W-1:0] prof_bits;

   zynq_csr_bank csr_bank (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .csr_wr_i     (csr_wr_i),
      .csr_re_i     (csr_re_i),
      .csr_raddr_i  (csr_raddr_i),
      .prof_bits_i  (prof_bits),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .dram_base_o  (dram_base),
      .core_reset_o (core_reset_o)
   );

   zynq_addr_map addr_map (
      .aclk_i      (aclk_i),
      .arst_n_i    (arst_n_i),
      .host_wr_i   (host_wr_i),
      .host_rd_i   (host_rd_i),
      .dram_wr_i   (dram_wr_i),
      .dram_rd_i   (dram_rd_i),
      .dram_base_i (dram_base),
      .core_wr_o   (core_wr_o),
      .core_rd_o   (core_rd_o),
      .ps_wr_o     (ps_wr_o),
      .ps_rd_o     (ps_rd_o)
   );

   // the profiler watches untranslated core addresses and clears with the core
   dram_profiler profiler (
      .aclk_i       (aclk_i),
      .core_reset_i (core_reset_o),
      .dram_wr_i    (dram_wr_i),
      .dram_rd_i    (dram_rd_i),
      .prof_bits_o  (prof_bits)
   );

endmodule

`default_nettype wire

// ==== verif/zynq_glue_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

module zynq_glue_chk (
   input logic                     aclk_i,
   input logic                     arst_n_i,
   input logic                     csr_re_i,
   input logic                     csr_rvalid_o,
   input zynq_glue_pkg::addr_req_t host_wr_i,
   input zynq_glue_pkg::addr_req_t host_rd_i,
   input zynq_glue_pkg::addr_req_t dram_wr_i,
   input zynq_glue_pkg::addr_req_t dram_rd_i,
   input zynq_glue_pkg::addr_req_t core_wr_o,
   input zynq_glue_pkg::addr_req_t core_rd_o,
   input zynq_glue_pkg::addr_req_t ps_wr_o,
   input zynq_glue_pkg::addr_req_t ps_rd_o,
   input logic                     core_reset_o
);

   // read valid is the read strobe delayed by exactly one cycle
   rvalid_after_re: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      csr_rvalid_o == $past(csr_re_i))
      else $error("read valid does not follow the read strobe by one cycle");

   // every translation channel is a single register stage
   valid_one_stage: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      core_wr_o.valid == $past(host_wr_i.valid) && core_rd_o.valid == $past(host_rd_i.valid) &&
      ps_wr_o.valid == $past(dram_wr_i.valid) && ps_rd_o.valid == $past(dram_rd_i.valid))
      else $error("an output valid differs from its input valid one cycle earlier");

   core_held_in_reset: assert property (@(posedge aclk_i) !arst_n_i |-> core_reset_o)
      else $error("core reset is low while the board reset is asserted");

   quiet_in_reset: assert property (@(posedge aclk_i) !arst_n_i |->
      !(csr_rvalid_o || core_wr_o.valid || core_rd_o.valid || ps_wr_o.valid || ps_rd_o.valid))
      else $error("an output valid is high while reset is asserted");

endmodule

`default_nettype wire

// ==== verif/zynq_glue_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "zynq_glue_config.svh"

module zynq_glue_tb;
   import zynq_glue_pkg::*;

   localparam int max_lines_lp = 64;
   localparam int rec_w_lp     = 4 + 4 * `ZG_DATA_W;

   // operation codes in the first column of the pattern file
   localparam logic [3:0] op_csr_wr  = 4'h1;
   localparam logic [3:0] op_csr_rd  = 4'h2;
   localparam logic [3:0] op_host_wr = 4'h3;
   localparam logic [3:0] op_host_rd = 4'h4;
   localparam logic [3:0] op_dram_wr = 4'h5;
   localparam logic [3:0] op_dram_rd = 4'h6;
   localparam logic [3:0] op_dram_2  = 4'h7;
   localparam logic [3:0] op_core_rst = 4'h8;

   logic                  aclk = 1'b0;
   logic                  arst_n;
   csr_wr_t               csr_wr;
   logic                  csr_re;
   csr_addr_e             csr_raddr;
   logic [`ZG_DATA_W-1:0] csr_rdata;
   logic                  csr_rvalid;
   addr_req_t             host_wr, host_rd, dram_wr, dram_rd;
   addr_req_t             core_wr, core_rd, ps_wr, ps_rd;
   logic                  core_reset;

   logic [rec_w_lp-1:0] patterns [max_lines_lp];
   int n_lines     = 0;
   int errors      = 0;
   int passed      = 0;
   int failed      = 0;
   int cycles      = 0;
   int cycle_limit = 1000;

   always #4 aclk = ~aclk;

   zynq_glue_top DUT (
      .aclk_i       (aclk),
      .arst_n_i     (arst_n),
      .csr_wr_i     (csr_wr),
      .csr_re_i     (csr_re),
      .csr_raddr_i  (csr_raddr),
      .csr_rdata_o  (csr_rdata),
      .csr_rvalid_o (csr_rvalid),
      .host_wr_i    (host_wr),
      .host_rd_i    (host_rd),
      .core_wr_o    (core_wr),
      .core_rd_o    (core_rd),
      .dram_wr_i    (dram_wr),
      .dram_rd_i    (dram_rd),
      .ps_wr_o      (ps_wr),
      .ps_rd_o      (ps_rd),
      .core_reset_o (core_reset)
   );

   bind zynq_glue_top zynq_glue_chk chk (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .csr_re_i     (csr_re_i),
      .csr_rvalid_o (csr_rvalid_o),
      .host_wr_i    (host_wr_i),
      .host_rd_i    (host_rd_i),
      .dram_wr_i    (dram_wr_i),
      .dram_rd_i    (dram_rd_i),
      .core_wr_o    (core_wr_o),
      .core_rd_o    (core_rd_o),
      .ps_wr_o      (ps_wr_o),
      .ps_rd_o      (ps_rd_o),
      .core_reset_o (core_reset_o)
   );

   always @(posedge aclk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic check_csr(input string what, input logic [`ZG_DATA_W-1:0] got,
                            input logic [`ZG_DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("ERROR @%0t: %s read %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_req(input string what, input addr_req_t got, input addr_req_t exp);
      if (got.valid !== exp.valid) begin
         $display("%s valid was %b in the cycle after the request, it should be %b",
                  what, got.valid, exp.valid);
         errors++;
      end else if (got.addr !== exp.addr) begin
         $display("ERROR @%0t: %s address %h, expected %h", $time, what, got.addr, exp.addr);
         errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic csr_write(input logic [`ZG_CSR_IDX_W-1:0] idx,
                            input logic [`ZG_DATA_W-1:0] wdata);
      @(posedge aclk);
      csr_wr <= '{we: 1'b1, idx: csr_addr_e'(idx), data: wdata};
      @(posedge aclk);
      csr_wr.we <= 1'b0;
   endtask

   task automatic csr_read(input logic [`ZG_CSR_IDX_W-1:0] idx,
                           input logic [`ZG_DATA_W-1:0] exp);
      int waited = 0;
      @(posedge aclk);
      csr_re    <= 1'b1;
      csr_raddr <= csr_addr_e'(idx);
      @(posedge aclk);
      csr_re <= 1'b0;
      @(negedge aclk);
      while (!csr_rvalid && waited < 4) begin
         @(negedge aclk);
         waited++;
      end
      if (csr_rvalid) begin
         check_csr($sformatf("register %0d", idx), csr_rdata, exp);
      end else begin
         $display("read of register %0d never returned a read valid", idx);
         errors++;
      end
   endtask

   // one request on one channel, the translated copy is due one cycle later
   task automatic send_req(input logic [3:0] op, input logic [`ZG_ADDR_W-1:0] addr,
                           input logic [`ZG_ADDR_W-1:0] exp);
      addr_req_t req;
      addr_req_t want;
      req  = '{valid: 1'b1, addr: addr};
      want = '{valid: 1'b1, addr: exp};
      @(posedge aclk);
      case (op)
         op_host_wr: host_wr <= req;
         op_host_rd: host_rd <= req;
         op_dram_wr: dram_wr <= req;
         default:    dram_rd <= req;
      endcase
      @(posedge aclk);
      host_wr <= '0;
      host_rd <= '0;
      dram_wr <= '0;
      dram_rd <= '0;
      @(negedge aclk);
      case (op)
         op_host_wr: check_req("core write", core_wr, want);
         op_host_rd: check_req("core read", core_rd, want);
         op_dram_wr: check_req("ps write", ps_wr, want);
         default:    check_req("ps read", ps_rd, want);
      endcase
   endtask

   // a DRAM write followed right away by a DRAM read, both in flight together
   task automatic send_pair(input logic [`ZG_ADDR_W-1:0] wr_addr, rd_addr, wr_exp, rd_exp);
      @(posedge aclk);
      dram_wr <= '{valid: 1'b1, addr: wr_addr};
      @(posedge aclk);
      dram_wr <= '0;
      dram_rd <= '{valid: 1'b1, addr: rd_addr};
      @(negedge aclk);
      check_req("ps write", ps_wr, addr_req_t'{valid: 1'b1, addr: wr_exp});
      @(posedge aclk);
      dram_rd <= '0;
      @(negedge aclk);
      check_req("ps read", ps_rd, addr_req_t'{valid: 1'b1, addr: rd_exp});
   endtask

   initial begin
      logic [3:0]            op;
      logic [`ZG_DATA_W-1:0] a, b, e, e2;
      int                    err_before;
      for (int i = 0; i < max_lines_lp; i++) begin
         patterns[i] = '0;
      end
      $readmemh("verif/zynq_glue_patterns.txt", patterns);
      while (n_lines < max_lines_lp && patterns[n_lines][rec_w_lp-1 -: 4] != 4'h0) begin
         n_lines++;
      end
      cycle_limit = 20 * n_lines + 100;

      arst_n    = 1'b0;
      csr_wr    = '0;
      csr_re    = 1'b0;
      csr_raddr = CSR_CTRL;
      host_wr   = '0;
      host_rd   = '0;
      dram_wr   = '0;
      dram_rd   = '0;
      repeat (16) @(posedge aclk);
      arst_n <= 1'b1;

      for (int i = 0; i < n_lines; i++) begin
         {op, a, b, e, e2} = patterns[i];
         err_before = errors;
         case (op)
            op_csr_wr:   csr_write(a[`ZG_CSR_IDX_W-1:0], b);
            op_csr_rd:   csr_read(a[`ZG_CSR_IDX_W-1:0], e);
            op_dram_2:   send_pair(a, b, e, e2);
            op_core_rst: begin
               @(negedge aclk);
               check_flag("core reset", core_reset, e[0]);
            end
            op_host_wr, op_host_rd, op_dram_wr, op_dram_rd: send_req(op, a, e);
            default: begin
               $display("pattern line %0d has an unknown operation %0h", i + 1, op);
               errors++;
            end
         endcase
         if (errors == err_before) begin
            passed++;
            $display("test %0d (op %0h): ok", i + 1, op);
         end else begin
            failed++;
            $display("test %0d (op %0h): failed", i + 1, op);
         end
      end

      if (n_lines == 0) begin
         $display("no pattern lines were loaded");
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors", n_lines, passed, failed, errors);
      if (errors == 0 && n_lines > 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/zynq_glue_patterns.txt ====
// op_a_b_exp_exp2: 1 reg write (a index, b data), 2 reg read (a index), 3/4 host wr/rd,
// 5/6 dram wr/rd (a address), 7 dram wr at a then rd at b, 8 core reset level in exp
8_00000000_00000000_00000001_00000000
2_00000000_00000000_00000000_00000000
2_00000001_00000000_00000000_00000000
2_00000002_00000000_00000000_00000000
2_00000003_00000000_00000000_00000000
2_00000004_00000000_00000000_00000000
2_00000005_00000000_00000000_00000000
2_00000006_00000000_00000000_00000000
1_00000000_00000001_00000000_00000000
8_00000000_00000000_00000000_00000000
1_00000001_00000001_00000000_00000000
1_00000002_10000000_00000000_00000000
2_00000000_00000000_00000001_00000000
2_00000001_00000000_00000001_00000000
2_00000002_00000000_10000000_00000000
2_00000007_00000000_00000000_00000000
3_00001234_00000000_80001234_00000000
4_2ABCDEF0_00000000_0ABCDEF0_00000000
4_3FFFFFFC_00000000_0FFFFFFC_00000000
5_80000040_00000000_10000040_00000000
7_80000100_80800200_10000100_10800200
2_00000003_00000000_00000003_00000000
5_80000000_00000000_10000000_00000000
6_80800000_00000000_10800000_00000000
5_9F800000_00000000_2F800000_00000000
2_00000003_00000000_00000003_00000000
2_00000004_00000000_80000000_00000000
2_00000005_00000000_00000000_00000000
1_00000004_12345678_00000000_00000000
2_00000004_00000000_80000000_00000000
1_00000000_00000000_00000000_00000000
8_00000000_00000000_00000001_00000000
2_00000003_00000000_00000000_00000000
2_00000004_00000000_00000000_00000000

// ==== list.f ====
+incdir+include
src/zynq_glue_pkg.sv
src/zynq_csr_bank.sv
src/zynq_addr_map.sv
src/dram_profiler.sv
src/zynq_glue_top.sv
verif/zynq_glue_chk.sv
verif/zynq_glue_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     ?= zynq_glue_tb
RTL_TOP    ?= zynq_glue_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/zynq_glue_config.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
